// File: verilog/alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

`define ALU_WORD_W 64
`define ALU_HALF_W 32
`define ALU_FLAGS_W 6
`define ALU_OP_W 5
`define ALU_COND_W 4

// flag word layout, C at the top
`define FLAG_C 5
`define FLAG_O 4
`define FLAG_A 3
`define FLAG_S 2
`define FLAG_Z 1
`define FLAG_P 0

`endif

// File: verilog/alu_pkg.sv
`include "alu_cfg.svh"

package alu_pkg;

  typedef logic [`ALU_WORD_W-1:0] word_t;
  typedef logic [`ALU_FLAGS_W-1:0] flags_t; // C,O,A,S,Z,P

  typedef enum logic [`ALU_OP_W-1:0] {
    OP_ADD64, OP_ADD32, OP_SUB64, OP_SUB32,
    OP_AND64, OP_AND32, OP_OR64, OP_OR32, OP_XOR64, OP_XOR32,
    OP_MOV64, OP_MOV32,
    OP_ZXT8, OP_ZXT16, OP_SXT8, OP_SXT16, OP_SXT32,
    OP_CMOV, OP_CSET
  } op_t;

  typedef enum logic [`ALU_COND_W-1:0] {
    CC_Z, CC_NZ, CC_S, CC_NS,
    CC_UGT, CC_ULE, CC_UGE, CC_ULT,
    CC_SGT, CC_SLE, CC_SGE, CC_SLT,
    CC_O, CC_NO, CC_P, CC_NP
  } cond_t;

  typedef struct packed {
    op_t    op;
    cond_t  cond;
    logic   thread;
    word_t  a;
    word_t  b;
    flags_t flags_in; // architectural flags at issue
  } alu_req_t;

  typedef struct packed {
    logic valid;
    logic thread;
  } alu_except_t;

  typedef struct packed {
    logic c64;
    logic c32;
    logic c4;
    logic ovf64;
    logic ovf32;
  } add_stat_t;

  typedef struct packed {
    word_t  result;
    flags_t flags;
    logic   sets_flags;
  } alu_resp_t;

endpackage

// File: verilog/alu_adder.sv
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_adder (
  input  alu_pkg::word_t     a,
  input  alu_pkg::word_t     b,
  input  logic               sub,
  output alu_pkg::word_t     sum,
  output alu_pkg::add_stat_t stat
);
  import alu_pkg::*;

  localparam int WORD_MSB = `ALU_WORD_W - 1;
  localparam int HALF_MSB = `ALU_HALF_W - 1;

  word_t                 b_eff;
  logic [`ALU_WORD_W:0]  full;
  logic [`ALU_HALF_W:0]  low;
  logic [4:0]            nib;

  assign b_eff = sub ? ~b : b; // two's complement, +1 comes in as carry

  assign full = {1'b0, a} + {1'b0, b_eff} + (`ALU_WORD_W+1)'(sub);
  // narrower copies only for the carry taps
  assign low = {1'b0, a[HALF_MSB:0]} + {1'b0, b_eff[HALF_MSB:0]} + (`ALU_HALF_W+1)'(sub);
  assign nib = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + 5'(sub);

  assign sum = full[WORD_MSB:0];

  assign stat.c64 = full[`ALU_WORD_W];
  assign stat.c32 = low[`ALU_HALF_W];
  assign stat.c4  = nib[4];

  // same-sign inputs with a sign flip in the sum
  assign stat.ovf64 = (a[WORD_MSB] == b_eff[WORD_MSB]) && (sum[WORD_MSB] != a[WORD_MSB]);
  assign stat.ovf32 = (a[HALF_MSB] == b_eff[HALF_MSB]) && (sum[HALF_MSB] != a[HALF_MSB]);

endmodule

// File: verilog/alu_cond_eval.sv
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_cond_eval (
  input  alu_pkg::cond_t  cond,
  input  alu_pkg::flags_t flags,
  output logic            taken
);
  import alu_pkg::*;

  logic c, o, s, z, p;

  assign c = flags[`FLAG_C];
  assign o = flags[`FLAG_O];
  assign s = flags[`FLAG_S];
  assign z = flags[`FLAG_Z];
  assign p = flags[`FLAG_P];

  always_comb begin
    case (cond)
      CC_Z:    taken = z;
      CC_NZ:   taken = ~z;
      CC_S:    taken = s;
      CC_NS:   taken = ~s;
      CC_UGT:  taken = ~(c | z);
      CC_ULE:  taken = c | z;
      CC_UGE:  taken = ~c;
      CC_ULT:  taken = c;
      CC_SGT:  taken = ~((s ^ o) | z);
      CC_SLE:  taken = (s ^ o) | z;
      CC_SGE:  taken = ~(s ^ o);
      CC_SLT:  taken = s ^ o;
      CC_O:    taken = o;
      CC_NO:   taken = ~o;
      CC_P:    taken = p;
      CC_NP:   taken = ~p;
      default: taken = 1'b0;
    endcase
  end

endmodule

// File: verilog/alu_result_mux.sv
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_result_mux (
  input  alu_pkg::alu_req_t req,
  input  alu_pkg::word_t    sum,
  input  logic              taken,
  output logic              sub,
  output alu_pkg::word_t    result
);
  import alu_pkg::*;

  localparam int UPPER_W  = `ALU_WORD_W - `ALU_HALF_W;
  localparam int HALF_MSB = `ALU_HALF_W - 1;

  word_t a;
  word_t b;
  word_t and_v;
  word_t or_v;
  word_t xor_v;

  assign a = req.a;
  assign b = req.b;

  assign and_v = a & b;
  assign or_v  = a | b;
  assign xor_v = a ^ b;

  assign sub = (req.op == OP_SUB64) || (req.op == OP_SUB32);

  always_comb begin
    case (req.op)
      OP_ADD64, OP_SUB64: result = sum;
      OP_ADD32, OP_SUB32: result = {{UPPER_W{1'b0}}, sum[HALF_MSB:0]};

      OP_AND64: result = and_v;
      OP_AND32: result = {{UPPER_W{1'b0}}, and_v[HALF_MSB:0]};
      OP_OR64:  result = or_v;
      OP_OR32:  result = {{UPPER_W{1'b0}}, or_v[HALF_MSB:0]};
      OP_XOR64: result = xor_v;
      OP_XOR32: result = {{UPPER_W{1'b0}}, xor_v[HALF_MSB:0]};

      OP_MOV64: result = b;
      OP_MOV32: result = {{UPPER_W{1'b0}}, b[HALF_MSB:0]};

      // extends always take the low field of b
      OP_ZXT8:  result = {{(`ALU_WORD_W-8){1'b0}}, b[7:0]};
      OP_ZXT16: result = {{(`ALU_WORD_W-16){1'b0}}, b[15:0]};
      OP_SXT8:  result = {{(`ALU_WORD_W-8){b[7]}}, b[7:0]};
      OP_SXT16: result = {{(`ALU_WORD_W-16){b[15]}}, b[15:0]};
      OP_SXT32: result = {{UPPER_W{b[HALF_MSB]}}, b[HALF_MSB:0]};

      OP_CMOV:  result = taken ? b : a;
      OP_CSET:  result = {{(`ALU_WORD_W-1){1'b0}}, taken}; // 0 or 1

      default:  result = '0;
    endcase
  end

endmodule

// File: verilog/alu_retire.sv
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_retire (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 data_en,
  input  alu_pkg::op_t         op,
  input  logic                 thread,
  input  alu_pkg::alu_except_t exc,
  input  alu_pkg::word_t       result,
  input  alu_pkg::add_stat_t   stat,
  output logic                 ret_en,
  output alu_pkg::alu_resp_t   resp
);
  import alu_pkg::*;

  localparam int WORD_MSB = `ALU_WORD_W - 1;
  localparam int HALF_MSB = `ALU_HALF_W - 1;

  word_t       result_q;
  add_stat_t   stat_q;
  op_t         op_q;
  logic        en_q;
  logic        inh_q;
  alu_except_t exc_q; // exception seen one cycle back

  logic   inhibit;
  logic   wide;
  logic   arith;
  logic   is_sub;
  logic   logic_op;
  logic   carry;
  logic   ovf;
  logic   sets_flags;
  flags_t calc;
  flags_t flags_out;

  // same-thread exception now or one cycle earlier kills the retire
  assign inhibit = (exc.valid && (exc.thread == thread)) ||
                   (exc_q.valid && (exc_q.thread == thread));

  always_ff @(posedge clk) begin
    if (rst) begin
      result_q <= '0;
      stat_q   <= '0;
      op_q     <= OP_ADD64;
      en_q     <= 1'b0;
      inh_q    <= 1'b0;
      exc_q    <= '0;
    end else begin
      result_q <= result;
      stat_q   <= stat;
      op_q     <= op;
      en_q     <= data_en;
      inh_q    <= inhibit;
      exc_q    <= exc;
    end
  end

  assign wide     = op_q inside {OP_ADD64, OP_SUB64, OP_AND64, OP_OR64, OP_XOR64};
  assign arith    = op_q inside {OP_ADD64, OP_ADD32, OP_SUB64, OP_SUB32};
  assign is_sub   = op_q inside {OP_SUB64, OP_SUB32};
  assign logic_op = op_q inside {OP_AND64, OP_AND32, OP_OR64, OP_OR32, OP_XOR64, OP_XOR32};

  assign carry = wide ? stat_q.c64 : stat_q.c32;
  assign ovf   = wide ? stat_q.ovf64 : stat_q.ovf32;

  always_comb begin
    calc = '0;
    calc[`FLAG_C] = arith & (carry ^ is_sub); // borrow on sub
    calc[`FLAG_O] = arith & ovf;
    calc[`FLAG_A] = arith & (stat_q.c4 ^ is_sub);
    calc[`FLAG_S] = wide ? result_q[WORD_MSB] : result_q[HALF_MSB];
    calc[`FLAG_Z] = wide ? (result_q == '0) : (result_q[HALF_MSB:0] == '0);
    calc[`FLAG_P] = ~^result_q[7:0]; // even parity of low byte
  end

  assign sets_flags = (arith | logic_op) & en_q;
  assign flags_out  = sets_flags ? calc : '0;

  assign resp = '{result: result_q, flags: flags_out, sets_flags: sets_flags};

  assign ret_en = en_q & ~inh_q;

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 data_en,
  input  alu_pkg::alu_req_t    req,
  input  alu_pkg::alu_except_t exc,
  output logic                 ret_en,
  output alu_pkg::alu_resp_t   resp
);
  import alu_pkg::*;

  word_t     sum;
  word_t     result;
  add_stat_t stat;
  logic      sub;
  logic      taken;

  alu_adder u_adder (
    .a   (req.a),
    .b   (req.b),
    .sub (sub),
    .sum (sum),
    .stat(stat)
  );

  alu_cond_eval u_cond (
    .cond (req.cond),
    .flags(req.flags_in),
    .taken(taken)
  );

  alu_result_mux u_mux (
    .req   (req),
    .sum   (sum),
    .taken (taken),
    .sub   (sub),
    .result(result)
  );

  alu_retire u_retire (
    .clk    (clk),
    .rst    (rst),
    .data_en(data_en),
    .op     (req.op),
    .thread (req.thread),
    .exc    (exc),
    .result (result),
    .stat   (stat),
    .ret_en (ret_en),
    .resp   (resp)
  );

endmodule

// File: tests/alu_sva.sv
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_sva (
  input logic                 clk,
  input logic                 rst,
  input logic                 data_en,
  input alu_pkg::alu_req_t    req,
  input alu_pkg::alu_except_t exc,
  input logic                 ret_en,
  input alu_pkg::alu_resp_t   resp
);
  import alu_pkg::*;

  logic half_op;
  logic same_thread_exc;

  assign half_op = req.op inside {OP_ADD32, OP_SUB32, OP_AND32, OP_OR32, OP_XOR32, OP_MOV32};
  assign same_thread_exc = exc.valid && (exc.thread == req.thread);

  // quiet in reset and on the first cycle out of it
  a_reset_quiet: assert property (@(posedge clk) $past(rst) |-> !ret_en)
    else $error("ret_en high during or right after reset");

  a_ret_has_issue: assert property (@(posedge clk) disable iff (rst)
    ret_en |-> $past(data_en))
    else $error("ret_en without a request one cycle earlier");

  a_half_upper_zero: assert property (@(posedge clk) disable iff (rst)
    (ret_en && $past(half_op)) |-> (resp.result[`ALU_WORD_W-1:`ALU_HALF_W] == '0))
    else $error("32-bit op retired with nonzero upper half");

  a_exc_kills: assert property (@(posedge clk) disable iff (rst)
    $past(data_en && same_thread_exc) |-> !ret_en)
    else $error("ret_en despite same-thread exception at issue");

endmodule

bind alu alu_sva u_sva (
  .clk    (clk),
  .rst    (rst),
  .data_en(data_en),
  .req    (req),
  .exc    (exc),
  .ret_en (ret_en),
  .resp   (resp)
);

// File: tests/alu_tb.sv
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_tb;
  import alu_pkg::*;

  typedef struct packed {
    logic [31:0] due; // cycle count at the checking negedge
    logic        ret_en;
    logic        check_resp;
    alu_resp_t   resp;
  } expect_t;

  localparam word_t SIGN_BITS = 64'h0000_0000_8000_8080; // bits 31, 15, 7

  logic        clk;
  logic        rst;
  logic        data_en;
  alu_req_t    req;
  alu_except_t exc;
  logic        ret_en;
  alu_resp_t   resp;

  expect_t     exp_q[$];
  alu_except_t prev_exc;
  logic [31:0] rng_state;
  int unsigned cyc = 0;
  int          checks = 0;
  int          errors = 0;
  int          err_mark = 0;
  int          test_num = 0;

  alu uut (
    .clk    (clk),
    .rst    (rst),
    .data_en(data_en),
    .req    (req),
    .exc    (exc),
    .ret_en (ret_en),
    .resp   (resp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic word_t rand_word();
    return {next_rand(), next_rand()};
  endfunction

  function automatic op_t pick_op(input int first, input int count);
    logic [31:0] v;
    v = next_rand() % count;
    return op_t'(5'(first + v));
  endfunction

  function automatic alu_req_t rand_req(input op_t op);
    alu_req_t r;
    logic [31:0] v;
    v = next_rand();
    r.op = op;
    r.cond = cond_t'(v[3:0]);
    r.thread = v[4];
    r.flags_in = v[10:5];
    r.a = rand_word();
    r.b = rand_word();
    return r;
  endfunction

  function automatic alu_except_t exc_on(input logic thread);
    alu_except_t e;
    e.valid = 1'b1;
    e.thread = thread;
    return e;
  endfunction

  // even codes are the plain test, odd codes its negation
  function automatic logic cond_holds(input cond_t cc, input flags_t f);
    logic c, o, s, z, p, base;
    c = f[`FLAG_C];
    o = f[`FLAG_O];
    s = f[`FLAG_S];
    z = f[`FLAG_Z];
    p = f[`FLAG_P];
    case (cc[3:1])
      3'd0: base = z;
      3'd1: base = s;
      3'd2: base = !c && !z; // unsigned above
      3'd3: base = !c;
      3'd4: base = !z && (s == o); // signed greater
      3'd5: base = (s == o);
      3'd6: base = o;
      default: base = p;
    endcase
    return base ^ cc[0];
  endfunction

  function automatic alu_resp_t model(input alu_req_t r);
    alu_resp_t e;
    logic wide, is_add, is_sub;
    word_t a, b;
    logic sa, sb, sr;
    e = '0;
    wide = r.op inside {OP_ADD64, OP_SUB64, OP_AND64, OP_OR64, OP_XOR64};
    is_add = r.op inside {OP_ADD64, OP_ADD32};
    is_sub = r.op inside {OP_SUB64, OP_SUB32};
    a = wide ? r.a : {32'h0, r.a[31:0]}; // operands cut to op width
    b = wide ? r.b : {32'h0, r.b[31:0]};
    case (r.op)
      OP_ADD64, OP_ADD32: e.result = a + b;
      OP_SUB64, OP_SUB32: e.result = a - b;
      OP_AND64, OP_AND32: e.result = a & b;
      OP_OR64, OP_OR32:   e.result = a | b;
      OP_XOR64, OP_XOR32: e.result = a ^ b;
      OP_MOV64: e.result = r.b;
      OP_MOV32: e.result = {32'h0, r.b[31:0]};
      OP_ZXT8:  e.result = 64'(r.b[7:0]);
      OP_ZXT16: e.result = 64'(r.b[15:0]);
      OP_SXT8:  e.result = 64'($signed(r.b[7:0]));
      OP_SXT16: e.result = 64'($signed(r.b[15:0]));
      OP_SXT32: e.result = 64'($signed(r.b[31:0]));
      OP_CMOV:  e.result = cond_holds(r.cond, r.flags_in) ? r.b : r.a;
      OP_CSET:  e.result = 64'(cond_holds(r.cond, r.flags_in));
      default:  e.result = '0;
    endcase
    if (!wide && (is_add || is_sub)) e.result[63:32] = '0;
    if (r.op inside {[OP_ADD64:OP_XOR32]}) begin
      e.sets_flags = 1'b1;
      sa = wide ? a[63] : a[31];
      sb = wide ? b[63] : b[31];
      sr = wide ? e.result[63] : e.result[31];
      e.flags[`FLAG_S] = sr;
      e.flags[`FLAG_Z] = (e.result == '0);
      e.flags[`FLAG_P] = ($countones(e.result[7:0]) % 2) == 0;
      if (is_add) begin
        e.flags[`FLAG_C] = e.result < a; // wrapped around
        e.flags[`FLAG_O] = (sa == sb) && (sr != sa);
        e.flags[`FLAG_A] = (5'(a[3:0]) + 5'(b[3:0])) > 5'd15;
      end else if (is_sub) begin
        e.flags[`FLAG_C] = a < b; // borrow
        e.flags[`FLAG_O] = (sa != sb) && (sr != sa);
        e.flags[`FLAG_A] = a[3:0] < b[3:0];
      end
    end
    return e;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_due();
    expect_t cur;
    if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      cur = exp_q.pop_front();
      check_value("ret_en", 64'(cur.ret_en), 64'(ret_en));
      if (cur.check_resp) begin
        check_value("resp.result", cur.resp.result, resp.result);
        check_value("resp.flags", 64'(cur.resp.flags), 64'(resp.flags));
        check_value("resp.sets_flags", 64'(cur.resp.sets_flags), 64'(resp.sets_flags));
      end
    end
  endtask

  // drive one cycle, then check the response that became due
  task automatic issue(input logic en, input alu_req_t r, input alu_except_t e);
    expect_t x;
    logic inhibit;
    @(posedge clk);
    data_en <= en;
    req <= r;
    exc <= e;
    inhibit = (e.valid && e.thread == r.thread) ||
              (prev_exc.valid && prev_exc.thread == r.thread);
    x.due = cyc + 2;
    x.ret_en = en && !inhibit;
    x.check_resp = en;
    x.resp = en ? model(r) : '0;
    exp_q.push_back(x);
    prev_exc = e;
    @(negedge clk);
    compare_due();
  endtask

  task automatic issue_ab(input op_t op, input word_t a, input word_t b);
    alu_req_t r;
    r = rand_req(op);
    r.a = a;
    r.b = b;
    issue(1'b1, r, '0);
  endtask

  task automatic finish_test(input string name);
    int n;
    n = 0;
    issue(1'b0, rand_req(OP_ADD64), '0); // bubble, drops data_en
    while (exp_q.size() != 0 && n < 16) begin
      @(negedge clk);
      compare_due();
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d responses never arrived in test %s", exp_q.size(), name);
      $display("TEST FAIL");
      $finish;
    end else begin
      test_num++;
      if (errors == err_mark) $display("test %0d %s: ok", test_num, name);
      else $display("test %0d %s: %0d errors", test_num, name, errors - err_mark);
      err_mark = errors;
    end
  endtask

  initial begin
    int i;
    int k;
    alu_req_t r;
    logic [31:0] v;
    alu_except_t e;
    rng_state = 32'h3ae79e1e;
    rst = 1'b1;
    data_en = 1'b0;
    req = '0;
    exc = '0;
    prev_exc = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    issue_ab(OP_ADD64, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1); // carry out and zero
    issue_ab(OP_ADD32, 64'hAAAA_0000_FFFF_FFFF, 64'h2);
    issue_ab(OP_SUB64, 64'h0, 64'h1);
    issue_ab(OP_SUB32, 64'h5, 64'h0000_0001_0000_0006);
    issue_ab(OP_ADD32, 64'h7FFF_FFFF, 64'h1); // signed overflow
    issue_ab(OP_SUB64, 64'h8000_0000_0000_0000, 64'h1);
    issue_ab(OP_SUB32, 64'h1234_5678_9ABC_DEF0, 64'h9ABC_DEF0);
    repeat (40) issue(1'b1, rand_req(pick_op(0, 4)), '0);
    finish_test("add/sub");

    repeat (36) issue(1'b1, rand_req(pick_op(4, 6)), '0);
    finish_test("logic");

    for (i = 10; i <= 16; i++) begin
      issue_ab(op_t'(5'(i)), rand_word(), rand_word() | SIGN_BITS);
      issue_ab(op_t'(5'(i)), rand_word(), rand_word() & ~SIGN_BITS);
    end
    repeat (14) issue(1'b1, rand_req(pick_op(10, 7)), '0);
    finish_test("move/extend");

    for (i = 0; i < 16; i++) begin
      for (k = 0; k < 3; k++) begin
        r = rand_req(OP_CMOV);
        r.cond = cond_t'(4'(i));
        issue(1'b1, r, '0);
        r.op = OP_CSET;
        issue(1'b1, r, '0);
      end
    end
    finish_test("cmov/cset");

    repeat (24) issue(1'b1, rand_req(pick_op(0, 19)), '0);
    repeat (30) begin
      v = next_rand();
      issue(v[0], rand_req(pick_op(0, 19)), '0);
    end
    finish_test("back-to-back");

    r = rand_req(OP_ADD64);
    r.thread = 1'b0;
    issue(1'b1, r, exc_on(1'b0)); // same thread, same cycle
    issue(1'b0, r, '0);
    issue(1'b1, r, exc_on(1'b1));
    issue(1'b0, r, exc_on(1'b0));
    issue(1'b1, r, '0); // killed by the cycle before
    issue(1'b0, r, exc_on(1'b1));
    issue(1'b1, r, '0);
    repeat (40) begin
      v = next_rand();
      e.valid = (v[2:1] == 2'b00);
      e.thread = v[3];
      issue(v[0], rand_req(pick_op(0, 19)), e);
    end
    finish_test("exception inhibit");

    $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: alu.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu_adder.sv
verilog/alu_cond_eval.sv
verilog/alu_result_mux.sv
verilog/alu_retire.sv
verilog/alu.sv
tests/alu_sva.sv
tests/alu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the alu testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module alu_tb -f alu.f > build.log 2>&1 \
  && ./obj_dir/Valu_tb > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "^TEST PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
